// ==== verilog/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ====================
// Core organization
// ====================

// Harts sharing the pipeline
// Four is the minimum that keeps the pipeline free of hazards
`define NUM_HARTS 4

// Data path width
`define XLEN 32

// ====================
// Memory sizing
// ====================

// Byte window owned by each hart in both memories
`define HART_SPAN 1024

// Depths in 32-bit words, one window per hart
`define IMEM_WORDS 1024
`define DMEM_WORDS 1024

`endif

// ==== verilog/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // Raw instruction and register index
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_idx_t;

    // Decoded operation
    // Anything outside the supported subset decodes to OP_NOP
    typedef enum logic [4:0] {
        OP_NOP,
        // Register ALU group
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        // Immediate group
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
        OP_SLTIU, OP_SLLI, OP_SRLI, OP_SRAI,
        // Upper immediate and word memory access
        OP_LUI, OP_LW, OP_SW
    } op_e;

    // ====================
    // Opcodes
    // ====================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 values, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // Width field of LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;

    // funct7, base form and alternate form (SUB, SRA, SRAI)
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// ==== verilog/barrel_pkg.sv ====
`include "core_macros.svh"

package barrel_pkg;

    // Hart number, wide enough for NUM_HARTS
    typedef logic [$clog2(`NUM_HARTS)-1:0] hart_id_t;

    // Byte program counter
    typedef logic [31:0] pc_t;

    // Data word
    typedef logic [`XLEN-1:0] word_t;

    // ====================
    // Memory addressing
    // ====================

    // Word addresses into the shared memories
    typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

endpackage

// ==== verilog/word_ram.sv ====
module word_ram #(
    parameter type word_type = logic [31:0],
    parameter int  DEPTH     = 1024
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_type                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_type                 rdata
);

    // Storage array, contents undefined until written
    word_type mem [DEPTH];

    // One write port, one registered read port
    // Same address in the same cycle returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// ==== verilog/instr_decoder.sv ====
module instr_decoder
    import rv32_isa_pkg::*, barrel_pkg::*;
(
    input  instr_t   instr,
    output op_e      op,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;

    // Fixed field positions
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // I, S and U immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // Operation and immediate select
    always_comb begin
        op  = OP_NOP;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: op = OP_ADD;
                        F3_SLL:     op = OP_SLL;
                        F3_SLT:     op = OP_SLT;
                        F3_SLTU:    op = OP_SLTU;
                        F3_XOR:     op = OP_XOR;
                        F3_SRL_SRA: op = OP_SRL;
                        F3_OR:      op = OP_OR;
                        default:    op = OP_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    // Only SUB and SRA use the alternate form
                    case (funct3)
                        F3_ADD_SUB: op = OP_SUB;
                        F3_SRL_SRA: op = OP_SRA;
                        default:    op = OP_NOP;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                imm = imm_i;
                case (funct3)
                    F3_ADD_SUB: op = OP_ADDI;
                    F3_SLT:     op = OP_SLTI;
                    F3_SLTU:    op = OP_SLTIU;
                    F3_XOR:     op = OP_XORI;
                    F3_OR:      op = OP_ORI;
                    F3_AND:     op = OP_ANDI;
                    // Shift amount lives in imm[4:0]
                    F3_SLL:     op = (funct7 == F7_BASE) ? OP_SLLI : OP_NOP;
                    default: begin
                        if (funct7 == F7_BASE) begin
                            op = OP_SRLI;
                        end else if (funct7 == F7_ALT) begin
                            op = OP_SRAI;
                        end
                    end
                endcase
            end
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_LOAD: begin
                imm = imm_i;
                // Word loads only
                if (funct3 == F3_WORD) begin
                    op = OP_LW;
                end
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == F3_WORD) begin
                    op = OP_SW;
                end
            end
            default: begin
                op = OP_NOP;
            end
        endcase
    end

endmodule

// ==== verilog/hart_regfile.sv ====
`include "core_macros.svh"

module hart_regfile
    import barrel_pkg::*, rv32_isa_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  hart_id_t rhart,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  hart_id_t whart,
    input  reg_idx_t wa,
    input  word_t    wd
);

    // One bank of 32 registers per hart
    word_t regs [`NUM_HARTS][32];

    // Write at the edge, x0 of every bank stays zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int h = 0; h < `NUM_HARTS; h++) begin
                for (int r = 0; r < 32; r++) begin
                    regs[h][r] <= '0;
                end
            end
        end else if (we && (wa != '0)) begin
            regs[whart][wa] <= wd;
        end
    end

    // Combinational reads from the decoding hart's bank
    assign rd1 = (ra1 == '0) ? '0 : regs[rhart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[rhart][ra2];

endmodule

// ==== verilog/exec_unit.sv ====
`include "core_macros.svh"

module exec_unit
    import rv32_isa_pkg::*, barrel_pkg::*;
(
    input  op_e        op,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  word_t      imm,
    input  hart_id_t   hart,
    output word_t      result,
    output dmem_addr_t dmem_addr
);

    logic       use_rs2;
    word_t      opb;
    logic [4:0] shamt;
    word_t      win_base;
    word_t      eff_addr;

    // ====================
    // Operand select
    // ====================

    // Register forms take rs2, everything else the immediate
    assign use_rs2 = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    assign opb     = use_rs2 ? rs2_val : imm;
    // Shifts only look at the low five bits
    assign shamt   = opb[4:0];

    // ====================
    // ALU
    // ====================
    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:   result = rs1_val + opb;
            OP_SUB:            result = rs1_val - opb;
            OP_AND, OP_ANDI:   result = rs1_val & opb;
            OP_OR, OP_ORI:     result = rs1_val | opb;
            OP_XOR, OP_XORI:   result = rs1_val ^ opb;
            OP_SLL, OP_SLLI:   result = rs1_val << shamt;
            OP_SRL, OP_SRLI:   result = rs1_val >> shamt;
            OP_SRA, OP_SRAI:   result = $signed(rs1_val) >>> shamt;
            // Set-less-than yields 0 or 1
            OP_SLT, OP_SLTI:   result = word_t'($signed(rs1_val) < $signed(opb));
            OP_SLTU, OP_SLTIU: result = word_t'(rs1_val < opb);
            // Immediate is already shifted into place by the decoder
            OP_LUI:            result = imm;
            default:           result = '0;
        endcase
    end

    // ====================
    // Data address
    // ====================

    // Hart window base plus rs1 plus offset
    assign win_base  = word_t'(hart) * word_t'(`HART_SPAN);
    assign eff_addr  = win_base + rs1_val + imm;
    // Word address, byte offset bits dropped
    assign dmem_addr = dmem_addr_t'(eff_addr >> 2);

endmodule

// ==== verilog/barrel_core.sv ====
`include "core_macros.svh"

module barrel_core
    import barrel_pkg::*, rv32_isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       run,
    input  logic       imem_we,
    input  imem_addr_t imem_addr,
    input  instr_t     imem_wdata,
    input  logic       dmem_we,
    input  dmem_addr_t dmem_addr,
    input  word_t      dmem_wdata,
    output logic       retire_valid,
    output hart_id_t   retire_hart,
    output pc_t        retire_pc,
    output logic       retire_we,
    output reg_idx_t   retire_rd,
    output word_t      retire_wdata
);

    // Sequencer
    hart_id_t   hart_cnt;
    pc_t        pc_bank [`NUM_HARTS];
    imem_addr_t fetch_addr;
    // Fetch stage
    logic       f_valid;
    hart_id_t   f_hart;
    pc_t        f_pc;
    instr_t     f_instr;
    op_e        dec_op;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    reg_idx_t   dec_rd;
    word_t      dec_imm;
    word_t      rs1_val;
    word_t      rs2_val;
    // Decode registers
    logic       d_valid;
    hart_id_t   d_hart;
    pc_t        d_pc;
    op_e        d_op;
    reg_idx_t   d_rd;
    word_t      d_rs1_val;
    word_t      d_rs2_val;
    word_t      d_imm;
    word_t      alu_result;
    dmem_addr_t ea_word;
    // Execute registers
    logic       x_valid;
    hart_id_t   x_hart;
    pc_t        x_pc;
    op_e        x_op;
    reg_idx_t   x_rd;
    logic       x_rf_we;
    logic       x_store;
    word_t      x_result;
    word_t      x_store_data;
    dmem_addr_t x_addr;
    word_t      load_data;
    // Write registers
    logic       w_valid;
    hart_id_t   w_hart;
    pc_t        w_pc;
    reg_idx_t   w_rd;
    logic       w_rf_we;
    logic       w_store;
    word_t      w_wdata;
    word_t      w_store_data;
    dmem_addr_t w_addr;
    // Data memory write port after the load/store mux
    logic       dm_we;
    dmem_addr_t dm_waddr;
    word_t      dm_wdata;

    // ====================
    // Hart sequencer
    // ====================

    // Strict round robin with PCs stepping by 4 only while running
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hart_cnt <= '0;
            for (int h = 0; h < `NUM_HARTS; h++) begin
                pc_bank[h] <= pc_t'(h * `HART_SPAN);
            end
        end else if (run) begin
            pc_bank[hart_cnt] <= pc_bank[hart_cnt] + pc_t'(4);
            if (hart_cnt == hart_id_t'(`NUM_HARTS - 1)) begin
                hart_cnt <= '0;
            end else begin
                hart_cnt <= hart_cnt + 1'b1;
            end
        end
    end

    // ====================
    // Fetch
    // ====================
    assign fetch_addr = imem_addr_t'(pc_bank[hart_cnt] >> 2);

    // Loaded through the write port while stopped
    word_ram #(.word_type(instr_t), .DEPTH(`IMEM_WORDS)) u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (fetch_addr),
        .rdata (f_instr)
    );

    // Slot is valid only when issued with run high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= run;
        end
    end

    always_ff @(posedge clk) begin
        f_hart <= hart_cnt;
        f_pc   <= pc_bank[hart_cnt];
    end

    // ====================
    // Decode and register read
    // ====================
    instr_decoder u_dec (
        .instr (f_instr),
        .op    (dec_op),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .rd    (dec_rd),
        .imm   (dec_imm)
    );

    // Reads use the fetching hart and writes come from the write stage
    hart_regfile u_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .rhart  (f_hart),
        .ra1    (dec_rs1),
        .ra2    (dec_rs2),
        .rd1    (rs1_val),
        .rd2    (rs2_val),
        .we     (w_rf_we),
        .whart  (w_hart),
        .wa     (w_rd),
        .wd     (w_wdata)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= f_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_hart    <= f_hart;
        d_pc      <= f_pc;
        d_op      <= dec_op;
        d_rd      <= dec_rd;
        d_rs1_val <= rs1_val;
        d_rs2_val <= rs2_val;
        d_imm     <= dec_imm;
    end

    // ====================
    // Execute
    // ====================

    // ALU result and data word address that goes straight to dmem
    exec_unit u_exec (
        .op        (d_op),
        .rs1_val   (d_rs1_val),
        .rs2_val   (d_rs2_val),
        .imm       (d_imm),
        .hart      (d_hart),
        .result    (alu_result),
        .dmem_addr (ea_word)
    );

    // Register write only for result-producing ops with rd other than x0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_valid <= 1'b0;
            x_rf_we <= 1'b0;
            x_store <= 1'b0;
        end else begin
            x_valid <= d_valid;
            x_rf_we <= d_valid && !(d_op inside {OP_NOP, OP_SW}) && (d_rd != '0);
            x_store <= d_valid && (d_op == OP_SW);
        end
    end

    always_ff @(posedge clk) begin
        x_hart       <= d_hart;
        x_pc         <= d_pc;
        x_op         <= d_op;
        x_rd         <= d_rd;
        x_result     <= alu_result;
        x_store_data <= d_rs2_val;
        x_addr       <= ea_word;
    end

    // Core stores own the write port only while running
    assign dm_we    = run ? w_store      : dmem_we;
    assign dm_waddr = run ? w_addr       : dmem_addr;
    assign dm_wdata = run ? w_store_data : dmem_wdata;

    word_ram #(.word_type(word_t), .DEPTH(`DMEM_WORDS)) u_dmem (
        .clk   (clk),
        .we    (dm_we),
        .waddr (dm_waddr),
        .wdata (dm_wdata),
        .raddr (ea_word),
        .rdata (load_data)
    );

    // ====================
    // Write
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_valid <= 1'b0;
            w_rf_we <= 1'b0;
            w_store <= 1'b0;
        end else begin
            w_valid <= x_valid;
            w_rf_we <= x_rf_we;
            w_store <= x_store;
        end
    end

    // Load data for LW and the ALU result otherwise
    always_ff @(posedge clk) begin
        w_hart       <= x_hart;
        w_pc         <= x_pc;
        w_rd         <= x_rd;
        w_wdata      <= (x_op == OP_LW) ? load_data : x_result;
        w_store_data <= x_store_data;
        w_addr       <= x_addr;
    end

    // Retire port mirrors the register file write
    assign retire_valid = w_valid;
    assign retire_hart  = w_hart;
    assign retire_pc    = w_pc;
    assign retire_we    = w_rf_we;
    assign retire_rd    = w_rd;
    assign retire_wdata = w_wdata;

endmodule

// ==== sim/core_sva.sv ====
`include "core_macros.svh"

module core_sva
    import barrel_pkg::*, rv32_isa_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     run,
    input logic     retire_valid,
    input hart_id_t retire_hart,
    input logic     retire_we,
    input reg_idx_t retire_rd
);

    // ====================
    // Retire port rules
    // ====================

    // Back-to-back retirements come from consecutive harts
    property hart_rotates;
        @(posedge clk) disable iff (!arst_n)
            (retire_valid && $past(retire_valid)) |->
                retire_hart == hart_id_t'((int'($past(retire_hart)) + 1) % `NUM_HARTS);
    endproperty

    // x0 is never a write target
    property no_x0_write;
        @(posedge clk) disable iff (!arst_n)
            retire_we |-> (retire_rd != '0);
    endproperty

    // A slot without run never reaches the write stage
    property idle_slot_empty;
        @(posedge clk) disable iff (!arst_n)
            !run |-> ##4 !retire_valid;
    endproperty

    a_hart_rotates: assert property (hart_rotates)
        else $error("retire_hart skipped a hart between back-to-back retirements");
    a_no_x0_write: assert property (no_x0_write)
        else $error("retire_we high with retire_rd equal to x0");
    a_idle_slot_empty: assert property (idle_slot_empty)
        else $error("retire_valid high four cycles after run was low");

endmodule

// ==== sim/tb_barrel_core.sv ====
`include "core_macros.svh"

module tb_barrel_core
    import rv32_isa_pkg::*, barrel_pkg::*;
();

    localparam int NH       = `NUM_HARTS;
    localparam int PROG_LEN = 40;
    // Covers reset and memory load plus one slot per instruction and slack
    localparam int WATCHDOG_CYCLES = 3 + `IMEM_WORDS + PROG_LEN * NH + 50;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       run;
    logic       imem_we;
    imem_addr_t imem_addr;
    instr_t     imem_wdata;
    logic       dmem_we;
    dmem_addr_t dmem_addr;
    word_t      dmem_wdata;
    logic       retire_valid;
    hart_id_t   retire_hart;
    pc_t        retire_pc;
    logic       retire_we;
    reg_idx_t   retire_rd;
    word_t      retire_wdata;

    // Stimulus and reference state
    logic [31:0] prog [NH][PROG_LEN];
    logic [31:0] ref_regs [NH][32];
    logic [31:0] ref_mem [`DMEM_WORDS];
    logic [31:0] lcg_state;
    int          ret_k [NH];
    int          ret_count = 0;
    int          errors = 0;
    int          cyc = 0;
    int          start_cyc = 0;
    // Run as sampled at the last four rising edges
    logic [3:0]  run_hist = '0;

    barrel_core UUT (.*);

    bind barrel_core core_sva u_sva (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        run_hist <= {run_hist[2:0], run};
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Preload pattern that differs for every word address
    function automatic logic [31:0] fill_word(input int a);
        logic [9:0] w;
        w = 10'(a);
        return {6'h2b, w, ~w, 6'h14};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // Label used in mismatch lines
    function automatic string op_class(input logic [31:0] ins);
        case (ins[6:0])
            7'b0110011: return "reg alu";
            7'b0010011: return "imm alu";
            7'b0110111: return "lui";
            7'b0000011: return "load";
            7'b0100011: return "store";
            default:    return "no-op";
        endcase
    endfunction

    // ====================
    // Program builder
    // ====================
    task automatic build_programs();
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] off;
        int          k;
        for (int h = 0; h < NH; h++) begin
            k = 0;
            while (k < PROG_LEN) begin
                r   = lcg_next();
                v   = lcg_next();
                rd  = {1'b0, r[31:28]};
                rs1 = {1'b0, r[27:24]};
                rs2 = {1'b0, r[23:20]};
                f3  = r[18:16];
                f7  = r[11] ? F7_ALT : F7_BASE;
                // Word offset inside the hart window
                off = {2'b00, v[7:0], 2'b00};
                if (k < 4) begin
                    // Seed x1 to x4 with full-width values
                    prog[h][k] = enc_u(5'(k + 1), v[31:12]);
                end else if (k < 8) begin
                    prog[h][k] = enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'(k - 3), 5'(k - 3), v[11:0]);
                end else if (k == 8) begin
                    // Same offset on every hart reads a different word in each window
                    prog[h][k] = enc_i(OPC_LOAD, F3_WORD, 5'd9, 5'd0, 12'd16);
                end else if (k == 9) begin
                    prog[h][k] = enc_i(OPC_OP_IMM, F3_SRL_SRA, 5'd10, 5'd1, {F7_ALT, 5'd31});
                end else if (k == 10) begin
                    // Every hart stores x1 and loads it back
                    prog[h][k] = enc_s(5'd0, 5'd1, 12'd32);
                end else if (k == 11) begin
                    prog[h][k] = enc_i(OPC_LOAD, F3_WORD, 5'd11, 5'd0, 12'd32);
                end else begin
                    case (r[14:12])
                        3'd0, 3'd1: begin
                            if (f3 != F3_ADD_SUB && f3 != F3_SRL_SRA) begin
                                f7 = F7_BASE;
                            end
                            prog[h][k] = enc_r(f7, f3, rd, rs1, rs2);
                        end
                        3'd2, 3'd3: begin
                            // Shifts carry funct7 in the upper immediate
                            if (f3 == F3_SLL) begin
                                prog[h][k] = enc_i(OPC_OP_IMM, f3, rd, rs1, {F7_BASE, v[4:0]});
                            end else if (f3 == F3_SRL_SRA) begin
                                prog[h][k] = enc_i(OPC_OP_IMM, f3, rd, rs1, {f7, v[4:0]});
                            end else begin
                                prog[h][k] = enc_i(OPC_OP_IMM, f3, rd, rs1, v[11:0]);
                            end
                        end
                        3'd4: prog[h][k] = enc_u(rd, v[31:12]);
                        3'd5: begin
                            // Store then load back from the same offset
                            if (k + 1 < PROG_LEN) begin
                                prog[h][k] = enc_s(5'd0, rs2, off);
                                k = k + 1;
                                prog[h][k] = enc_i(OPC_LOAD, F3_WORD, rd, 5'd0, off);
                            end else begin
                                prog[h][k] = '0;
                            end
                        end
                        3'd6: prog[h][k] = enc_i(OPC_LOAD, F3_WORD, rd, 5'd0, off);
                        default: begin
                            // Branch opcode is outside the subset
                            if (r[11]) begin
                                prog[h][k] = {v[31:7], 7'b1100011};
                            end else begin
                                prog[h][k] = enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd0, rs1, v[11:0]);
                            end
                        end
                    endcase
                end
                k = k + 1;
            end
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction of hart h in program order
    function automatic void ref_step(input int h, input logic [31:0] ins,
                                     output logic we, output logic [31:0] wd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic        writes;
        f3     = ins[14:12];
        f7     = ins[31:25];
        rd     = ins[11:7];
        a      = ref_regs[h][ins[19:15]];
        b      = ref_regs[h][ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        writes = 1'b0;
        wd     = '0;
        case (ins[6:0])
            7'b0110011: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
                    writes = 1'b1;
                    wd     = alu(f3, f7 == 7'h20, a, b);
                end
            end
            7'b0010011: begin
                if (f3 == 3'b001) begin
                    writes = (f7 == 7'h00);
                end else if (f3 == 3'b101) begin
                    writes = (f7 == 7'h00 || f7 == 7'h20);
                end else begin
                    writes = 1'b1;
                end
                wd = alu(f3, f3 == 3'b101 && f7 == 7'h20, a, imm_i);
            end
            7'b0110111: begin
                writes = 1'b1;
                wd     = {ins[31:12], 12'b0};
            end
            7'b0000011: begin
                ea     = h * `HART_SPAN + a + imm_i;
                writes = (f3 == 3'b010);
                wd     = ref_mem[ea[11:2]];
            end
            7'b0100011: begin
                ea = h * `HART_SPAN + a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (f3 == 3'b010) begin
                    ref_mem[ea[11:2]] = b;
                end
            end
            default: writes = 1'b0;
        endcase
        we = writes && (rd != 5'd0);
        if (we) begin
            ref_regs[h][rd] = wd;
        end
    endfunction

    task automatic report_mismatch(input string name, input int h, input int k,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h (hart %0d, instruction %0d)",
                 name, exp, act, h, k);
        errors++;
    endtask

    // ====================
    // Comparator
    // ====================
    always @(negedge clk) begin
        int          h;
        int          k;
        logic [31:0] ins;
        logic [31:0] exp_pc;
        logic [31:0] exp_wd;
        logic        exp_we;
        if (retire_valid) begin
            // Expected slot follows strict round robin
            h      = ret_count % NH;
            k      = ret_k[h];
            ins    = (k < PROG_LEN) ? prog[h][k] : 32'h0;
            exp_pc = h * `HART_SPAN + 4 * k;
            ref_step(h, ins, exp_we, exp_wd);
            if (!run_hist[3]) begin
                $display("Error: retirement seen although run was low at its issue slot");
                errors++;
            end
            if (ret_count == 0 && cyc != start_cyc + 4) begin
                report_mismatch("first retire cycle", h, k, start_cyc + 4, cyc);
            end
            if (retire_hart !== hart_id_t'(h)) begin
                report_mismatch("hart order", h, k, h, 32'(retire_hart));
            end
            if (retire_pc !== exp_pc) begin
                report_mismatch("pc step", h, k, exp_pc, retire_pc);
            end
            if (retire_rd !== ins[11:7]) begin
                report_mismatch({op_class(ins), " rd"}, h, k, ins[11:7], 32'(retire_rd));
            end
            if (retire_we !== exp_we) begin
                report_mismatch({op_class(ins), " we"}, h, k, exp_we, 32'(retire_we));
            end
            if (exp_we && retire_wdata !== exp_wd) begin
                report_mismatch({op_class(ins), " wdata"}, h, k, exp_wd, retire_wdata);
            end
            ret_k[h]  = k + 1;
            ret_count = ret_count + 1;
        end else if (run_hist[3]) begin
            $display("Error: no retirement for a slot that issued with run high");
            errors++;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        arst_n     = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dmem_we    = 1'b0;
        dmem_addr  = '0;
        dmem_wdata = '0;
        lcg_state  = 32'h115205e6;
        for (int h = 0; h < NH; h++) begin
            ret_k[h] = 0;
            for (int r = 0; r < 32; r++) begin
                ref_regs[h][r] = '0;
            end
        end
        for (int a = 0; a < `DMEM_WORDS; a++) begin
            ref_mem[a] = fill_word(a);
        end
        build_programs();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        // Load both memories while stopped with zeros past each program
        for (int a = 0; a < `IMEM_WORDS; a++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = imem_addr_t'(a);
            imem_wdata = ((a % (`HART_SPAN / 4)) < PROG_LEN) ?
                         prog[a / (`HART_SPAN / 4)][a % (`HART_SPAN / 4)] : '0;
            dmem_we    = (a < `DMEM_WORDS);
            dmem_addr  = dmem_addr_t'(a);
            dmem_wdata = fill_word(a);
        end
        @(negedge clk);
        imem_we   = 1'b0;
        dmem_we   = 1'b0;
        run       = 1'b1;
        start_cyc = cyc;
        wait (ret_count >= NH * PROG_LEN);
        @(negedge clk);
        run = 1'b0;
        // Let the four-stage pipeline drain
        repeat (6) @(negedge clk);
        $display("Errors: %0d, retirements checked: %0d", errors, ret_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired, retirements stopped after %0d of %0d",
                 ret_count, NH * PROG_LEN);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/rv32_isa_pkg.sv
verilog/barrel_pkg.sv
verilog/word_ram.sv
verilog/instr_decoder.sv
verilog/hart_regfile.sv
verilog/exec_unit.sv
verilog/barrel_core.sv
sim/core_sva.sv
sim/tb_barrel_core.sv

// ==== Makefile ====
# Verilator build for the barrel-threaded core
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_barrel_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
